//--- verilog/div_macros.svh
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// data word width
`define DIV_XLEN 64

// enough bits to count down one step per data bit
`define DIV_CNT_W 6

// bits per lookahead group in the carry-lookahead adder
`define DIV_GROUP 4

`endif

//--- verilog/div_pkg.sv
`include "div_macros.svh"

package div_pkg;

  // operand, magnitude or result word
  typedef logic [`DIV_XLEN-1:0] dword_t;

  // remaining iteration steps
  typedef logic [`DIV_CNT_W-1:0] step_cnt_t;

  // op[0] selects signed operands, op[1] selects the remainder
  typedef logic [1:0] div_op_t;

  // core sequencing
  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_fix,
    st_done
  } div_state_t;

endpackage

//--- verilog/cla_64.sv
`timescale 1ns/1ps
`include "div_macros.svh"

module cla_64
  import div_pkg::*;
(
  input  dword_t a,
  input  dword_t b,
  input  logic   cin,
  output dword_t sum,
  output logic   cout
);

  localparam int N  = `DIV_XLEN;
  localparam int G  = `DIV_GROUP;
  localparam int NG = N / G;
  // each super group spans G groups
  localparam int NS = NG / G;

  dword_t          g;
  dword_t          p;
  logic [NG-1:0]   gg;
  logic [NG-1:0]   gp;
  logic [NS-1:0]   sg;
  logic [NS-1:0]   sp;
  logic [NS:0]     sc;
  logic [NG:0]     gc;
  logic [N:0]      c;
  logic [G:0]      t;

  // carries out of every position of one group as a flat sum of products
  function automatic logic [G:0] lookahead(input logic [G-1:0] gi,
                                           input logic [G-1:0] pi,
                                           input logic         ci);
    logic [G:0] cv;
    logic       term;
    logic       pp;
    cv[0] = ci;
    for (int k = 0; k < G; k++) begin
      term = gi[k];
      pp   = pi[k];
      for (int j = k - 1; j >= 0; j--) begin
        term = term | (pp & gi[j]);
        pp   = pp & pi[j];
      end
      cv[k+1] = term | (pp & ci);
    end
    return cv;
  endfunction

  assign g = a & b;
  assign p = a ^ b;

  always_comb begin
    // first level generate and propagate per group
    for (int i = 0; i < NG; i++) begin
      t     = lookahead(g[i*G +: G], p[i*G +: G], 1'b0);
      gg[i] = t[G];
      gp[i] = &p[i*G +: G];
    end
    // second level over the groups
    for (int s = 0; s < NS; s++) begin
      t     = lookahead(gg[s*G +: G], gp[s*G +: G], 1'b0);
      sg[s] = t[G];
      sp[s] = &gp[s*G +: G];
    end
    sc = lookahead(sg, sp, cin);
    // group carries inside each super group
    for (int s = 0; s < NS; s++) begin
      t             = lookahead(gg[s*G +: G], gp[s*G +: G], sc[s]);
      gc[s*G +: G]  = t[G-1:0];
    end
    gc[NG] = sc[NS];
    // bit carries inside each group
    for (int i = 0; i < NG; i++) begin
      t            = lookahead(g[i*G +: G], p[i*G +: G], gc[i]);
      c[i*G +: G]  = t[G-1:0];
    end
    c[N] = gc[NG];
  end

  assign sum  = p ^ c[N-1:0];
  assign cout = c[N];

endmodule

//--- verilog/div_nr_core.sv
`timescale 1ns/1ps
`include "div_macros.svh"

module div_nr_core
  import div_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   in_valid,
  output logic   in_ready,
  input  logic   flush,
  input  dword_t dividend_mag,
  input  dword_t divisor_mag,
  output logic   load,
  output dword_t quotient_mag,
  output dword_t remainder_mag,
  output logic   out_valid,
  input  logic   out_ready
);

  localparam int XLEN = `DIV_XLEN;

  div_state_t      state;
  step_cnt_t       cnt;

  // {sign, partial remainder, quotient}
  // the extra sign bit keeps full-width unsigned divisors exact
  logic [2*XLEN:0] rq;
  dword_t          div_q;
  logic [XLEN:0]   div_neg;

  logic            rem_neg;
  dword_t          step_b;
  logic            step_b_msb;
  dword_t          step_sum;
  logic            step_cout;
  logic            step_sign;
  dword_t          fix_sum;

  assign in_ready  = (state == st_idle);
  assign out_valid = (state == st_done);
  assign load      = in_valid & in_ready;

  assign rem_neg = rq[2*XLEN];

  // subtract while the partial remainder is non-negative, else add back
  assign step_b     = rem_neg ? div_q : div_neg[XLEN-1:0];
  assign step_b_msb = rem_neg ? 1'b0 : div_neg[XLEN];

  // low 64 bits of the remainder shifted left by one
  cla_64 step_add_i (
    .a    (rq[2*XLEN-2:XLEN-1]),
    .b    (step_b),
    .cin  (1'b0),
    .sum  (step_sum),
    .cout (step_cout)
  );

  // top bit of the 65-bit step result
  assign step_sign = rq[2*XLEN-1] ^ step_b_msb ^ step_cout;

  // restores a negative final remainder
  cla_64 fix_add_i (
    .a    (rq[2*XLEN-1:XLEN]),
    .b    (div_q),
    .cin  (1'b0),
    .sum  (fix_sum),
    .cout ()
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      cnt   <= '0;
    end else if (flush) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (load) begin
            state <= st_busy;
            cnt   <= step_cnt_t'(XLEN - 1);
          end
        end
        st_busy: begin
          if (cnt == '0) begin
            state <= st_fix;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        st_fix: begin
          state <= st_done;
        end
        st_done: begin
          // hold the result until it is taken
          if (out_ready) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rq      <= {1'b0, {XLEN{1'b0}}, dividend_mag};
      div_q   <= divisor_mag;
      div_neg <= -{1'b0, divisor_mag};
    end else if (state == st_busy) begin
      // quotient bit is set when the new remainder is non-negative
      rq <= {step_sign, step_sum, rq[XLEN-2:0], ~step_sign};
    end else if (state == st_fix) begin
      if (rem_neg) begin
        rq[2*XLEN:XLEN] <= {1'b0, fix_sum};
      end
    end
  end

  assign quotient_mag  = rq[XLEN-1:0];
  assign remainder_mag = rq[2*XLEN-1:XLEN];

endmodule

//--- verilog/div_sign_unit.sv
`timescale 1ns/1ps
`include "div_macros.svh"

module div_sign_unit
  import div_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    load,
  input  dword_t  dividend,
  input  dword_t  divisor,
  input  div_op_t op,
  output dword_t  dividend_mag,
  output dword_t  divisor_mag,
  input  dword_t  quotient_mag,
  input  dword_t  remainder_mag,
  output dword_t  result
);

  localparam int MSB = `DIV_XLEN - 1;

  logic   dividend_neg;
  logic   divisor_neg;
  logic   q_neg_q;
  logic   r_neg_q;
  logic   rem_sel_q;
  logic   div_zero_q;
  dword_t dividend_q;
  dword_t quotient;
  dword_t remainder;

  function automatic dword_t negate(input dword_t v);
    return ~v + dword_t'(1);
  endfunction

  // negative only when the signed bit is set
  assign dividend_neg = op[0] & dividend[MSB];
  assign divisor_neg  = op[0] & divisor[MSB];

  assign dividend_mag = dividend_neg ? negate(dividend) : dividend;
  assign divisor_mag  = divisor_neg ? negate(divisor) : divisor;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_neg_q    <= 1'b0;
      r_neg_q    <= 1'b0;
      rem_sel_q  <= 1'b0;
      div_zero_q <= 1'b0;
    end else if (load) begin
      q_neg_q    <= dividend_neg ^ divisor_neg;
      r_neg_q    <= dividend_neg;
      rem_sel_q  <= op[1];
      div_zero_q <= (divisor == '0);
    end
  end

  // original dividend is returned as remainder on divide by zero
  always_ff @(posedge clk) begin
    if (load) begin
      dividend_q <= dividend;
    end
  end

  // most negative / -1 falls out of the magnitude path with no extra case
  assign quotient  = div_zero_q ? '1 :
                     (q_neg_q ? negate(quotient_mag) : quotient_mag);
  assign remainder = div_zero_q ? dividend_q :
                     (r_neg_q ? negate(remainder_mag) : remainder_mag);

  assign result = rem_sel_q ? remainder : quotient;

endmodule

//--- verilog/div_top.sv
`timescale 1ns/1ps

module div_top
  import div_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,
  output logic    in_ready,
  input  dword_t  dividend,
  input  dword_t  divisor,
  input  div_op_t op,
  input  logic    flush,
  output logic    out_valid,
  input  logic    out_ready,
  output dword_t  result
);

  logic   load;
  dword_t dividend_mag;
  dword_t divisor_mag;
  dword_t quotient_mag;
  dword_t remainder_mag;

  // operand magnitudes in, signed result out
  div_sign_unit sign_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .load          (load),
    .dividend      (dividend),
    .divisor       (divisor),
    .op            (op),
    .dividend_mag  (dividend_mag),
    .divisor_mag   (divisor_mag),
    .quotient_mag  (quotient_mag),
    .remainder_mag (remainder_mag),
    .result        (result)
  );

  div_nr_core core_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .flush         (flush),
    .dividend_mag  (dividend_mag),
    .divisor_mag   (divisor_mag),
    .load          (load),
    .quotient_mag  (quotient_mag),
    .remainder_mag (remainder_mag),
    .out_valid     (out_valid),
    .out_ready     (out_ready)
  );

endmodule

//--- verification/div_tb.sv
`timescale 1ns/1ps

module div_tb
  import div_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam logic [31:0] SEED = 32'd94788;
  localparam int N_RAND = 40;
  // count loads 63 on acceptance, 64 step edges, then the fix edge
  localparam int LATENCY = 65;
  // all operations of all tests rounded up
  localparam int NUM_OPS = 200;
  localparam dword_t MIN_NEG = {1'b1, 63'b0};

  logic    clk;
  logic    rst_n;
  logic    in_valid;
  logic    in_ready;
  logic    flush;
  logic    out_valid;
  logic    out_ready;
  dword_t  dividend;
  dword_t  divisor;
  dword_t  result;
  div_op_t op;
  logic [31:0] lfsr;
  int      n_pass;
  int      n_fail;

  div_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .dividend  (dividend),
    .divisor   (divisor),
    .op        (op),
    .flush     (flush),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (NUM_OPS * 70 + 100) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", NUM_OPS * 70 + 100);
    $display("Verification failed");
    $finish;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output dword_t w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      w    = {w[62:0], lfsr[0]};
    end
  endtask

  // RISC-V division rules with the divide by zero and overflow cases
  function automatic dword_t ref_div(input dword_t a, input dword_t b, input div_op_t o);
    dword_t q;
    dword_t r;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (o[0] && a == MIN_NEG && b == '1) begin
      q = a;
      r = '0;
    end else if (o[0]) begin
      q = dword_t'($signed(a) / $signed(b));
      r = dword_t'($signed(a) % $signed(b));
    end else begin
      q = a / b;
      r = a % b;
    end
    return o[1] ? r : q;
  endfunction

  task automatic check_value(input string name, input dword_t exp, input dword_t act);
    assert (act === exp) begin
      n_pass++;
    end else begin
      $display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp, act);
      n_fail++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) begin
      n_pass++;
    end else begin
      $display("Error at %0d ns: %s", $time, what);
      n_fail++;
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!in_ready && n < 2 * LATENCY) begin
      @(negedge clk);
      n++;
    end
    check_true(in_ready, "divider never became ready for input");
  endtask

  task automatic drive_input(input dword_t a, input dword_t b, input div_op_t o);
    dividend = a;
    divisor  = b;
    op       = o;
    in_valid = 1'b1;
  endtask

  // one operation whose result is held back for hold cycles before it is taken
  task automatic run_op(input dword_t a, input dword_t b, input div_op_t o, input int hold);
    dword_t expected;
    int     edges;
    expected = ref_div(a, b, o);
    wait_ready();
    drive_input(a, b, o);
    @(negedge clk);
    in_valid = 1'b0;
    edges    = 0;
    while (!out_valid && edges < 2 * LATENCY) begin
      @(negedge clk);
      edges++;
    end
    check_true(out_valid, "no result after the operation was accepted");
    check_value("latency", dword_t'(LATENCY), dword_t'(edges));
    check_value("result", expected, result);
    repeat (hold) begin
      @(negedge clk);
      check_value("result", expected, result);
      check_true(out_valid && !in_ready, "handshake changed while the result was held");
    end
    out_ready = 1'b1;
    @(negedge clk);
    out_ready = 1'b0;
    check_true(in_ready && !out_valid, "result was not taken");
  endtask

  task automatic both_ops(input dword_t a, input dword_t b, input logic sgn);
    run_op(a, b, {1'b0, sgn}, 0);
    run_op(a, b, {1'b1, sgn}, 0);
  endtask

  task automatic finish_test(input string name, input int fails_before);
    $display("test %-14s %s", name, (n_fail == fails_before) ? "ok" : "FAILED");
  endtask

  task automatic rand_pairs(input logic sgn);
    dword_t a;
    dword_t b;
    dword_t sh;
    for (int i = 0; i < N_RAND; i++) begin
      rand_bits(64, a);
      rand_bits(64, b);
      rand_bits(6, sh);
      // spread the quotient sizes
      b = sgn ? dword_t'($signed(b) >>> sh) : b >> sh;
      both_ops(a, b, sgn);
    end
  endtask

  task automatic test_reset();
    int f;
    f = n_fail;
    check_true(in_ready && !out_valid, "divider not idle after reset");
    run_op(64'd100, 64'd7, 2'b00, 0);
    finish_test("reset", f);
  endtask

  task automatic test_unsigned();
    int f;
    f = n_fail;
    both_ops(64'd7, 64'd10, 1'b0);
    both_ops(64'd10, 64'd10, 1'b0);
    both_ops('1, 64'd1, 1'b0);
    both_ops('1, '1, 1'b0);
    both_ops('1, 64'd3, 1'b0);
    both_ops(MIN_NEG, 64'd1000, 1'b0);
    rand_pairs(1'b0);
    finish_test("unsigned", f);
  endtask

  task automatic test_signed();
    int f;
    f = n_fail;
    both_ops(dword_t'(100), dword_t'(7), 1'b1);
    both_ops(dword_t'(-100), dword_t'(7), 1'b1);
    both_ops(dword_t'(100), dword_t'(-7), 1'b1);
    both_ops(dword_t'(-100), dword_t'(-7), 1'b1);
    rand_pairs(1'b1);
    finish_test("signed", f);
  endtask

  task automatic test_special();
    int f;
    f = n_fail;
    both_ops(64'd12345, '0, 1'b0);
    both_ops(dword_t'(-12345), '0, 1'b1);
    both_ops(MIN_NEG, '1, 1'b1);
    finish_test("special", f);
  endtask

  task automatic test_backpressure();
    int f;
    f = n_fail;
    for (int i = 0; i < 4; i++) begin
      run_op(dword_t'(1000 + i), 64'd9, div_op_t'(i), 4 * i + 1);
    end
    finish_test("backpressure", f);
  endtask

  task automatic test_flush();
    int f;
    f = n_fail;
    wait_ready();
    drive_input(64'd5000, 64'd3, 2'b00);
    @(negedge clk);
    in_valid = 1'b0;
    repeat (20) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    check_true(in_ready && !out_valid, "flush did not return the divider to idle");
    // flush on the accepting edge drops the input
    drive_input(64'd77, 64'd5, 2'b00);
    flush = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
    flush    = 1'b0;
    check_true(in_ready && !out_valid, "input was accepted during a flush");
    run_op(dword_t'(-999), dword_t'(13), 2'b11, 0);
    finish_test("flush", f);
  endtask

  initial begin
    lfsr      = SEED;
    n_pass    = 0;
    n_fail    = 0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    dividend  = '0;
    divisor   = '0;
    op        = '0;
    flush     = 1'b0;
    out_ready = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_unsigned();
    test_signed();
    test_special();
    test_backpressure();
    test_flush();
    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+verilog
verilog/div_pkg.sv
verilog/cla_64.sv
verilog/div_nr_core.sv
verilog/div_sign_unit.sv
verilog/div_top.sv
verification/div_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the divider testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module div_tb -o div_sim

out=$(./obj_dir/div_sim)
echo "$out"

# the run passes only when the testbench reports a pass
echo "$out" | grep -q "^Verification passed$"
